// File: include/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// data word width
`define EX_XLEN    32

// shift amount taken from op2
`define EX_SHAMT_W 5

// leading-one position and divide step counter, wide enough to hold 32
`define EX_CNT_W   6

`endif

// File: source/ex_pkg.sv
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] xlen_t;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } ex_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } ex_unit_t;

    typedef struct packed {
        ex_unit_t unit;
        ex_op_t   op;
        xlen_t    mag_a;      // |op1| for signed forms
        xlen_t    mag_b;
        logic     neg_a;
        logic     neg_b;
        logic     want_high;  // upper product word
        logic     want_rem;
    } ex_prep_t;

    typedef struct packed {
        xlen_t quo_mag;
        xlen_t rem_mag;
        logic  valid;
    } ex_div_out_t;

endpackage

// File: source/ex_operand_prep.sv
`timescale 1ns/100ps

module ex_operand_prep (
    input  ex_pkg::ex_op_t   op,
    input  ex_pkg::xlen_t    op1,
    input  ex_pkg::xlen_t    op2,
    output ex_pkg::ex_prep_t prep
);
    import ex_pkg::*;

    ex_unit_t unit;
    logic     sign_a;  // op1 read as signed
    logic     sign_b;
    logic     want_high;
    logic     want_rem;
    logic     neg_a;
    logic     neg_b;

    always_comb begin
        unit      = UNIT_ALU;
        sign_a    = 1'b0;
        sign_b    = 1'b0;
        want_high = 1'b0;
        want_rem  = 1'b0;
        case (op)
            OP_MUL: unit = UNIT_MUL;  // low word is sign independent
            OP_MULH: begin
                unit      = UNIT_MUL;
                want_high = 1'b1;
                sign_a    = 1'b1;
                sign_b    = 1'b1;
            end
            OP_MULHSU: begin
                unit      = UNIT_MUL;
                want_high = 1'b1;
                sign_a    = 1'b1;
            end
            OP_MULHU: begin
                unit      = UNIT_MUL;
                want_high = 1'b1;
            end
            OP_DIV: begin
                unit   = UNIT_DIV;
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            OP_DIVU: unit = UNIT_DIV;
            OP_REM: begin
                unit     = UNIT_DIV;
                want_rem = 1'b1;
                sign_a   = 1'b1;
                sign_b   = 1'b1;
            end
            OP_REMU: begin
                unit     = UNIT_DIV;
                want_rem = 1'b1;
            end
            default: unit = UNIT_ALU;
        endcase
    end

    // shared absolute value step for mul and div
    assign neg_a = sign_a & op1[$bits(xlen_t)-1];
    assign neg_b = sign_b & op2[$bits(xlen_t)-1];

    assign prep.unit      = unit;
    assign prep.op        = op;
    assign prep.mag_a     = neg_a ? (~op1 + 1'b1) : op1;
    assign prep.mag_b     = neg_b ? (~op2 + 1'b1) : op2;
    assign prep.neg_a     = neg_a;
    assign prep.neg_b     = neg_b;
    assign prep.want_high = want_high;
    assign prep.want_rem  = want_rem;

endmodule

// File: source/ex_alu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_alu (
    input  ex_pkg::ex_prep_t prep,
    input  ex_pkg::xlen_t    op1,
    input  ex_pkg::xlen_t    op2,
    output ex_pkg::xlen_t    alu_res,
    output ex_pkg::xlen_t    addr_res
);
    import ex_pkg::*;

    function automatic xlen_t bit_rev(input xlen_t v);
        xlen_t r;
        for (int i = 0; i < `EX_XLEN; i++) begin
            r[i] = v[`EX_XLEN-1-i];
        end
        return r;
    endfunction

    logic                   is_sub;
    logic                   is_sll;
    xlen_t                  add_b;
    xlen_t                  sum;
    logic                   slt;
    logic                   sltu;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   fill;
    xlen_t                  sh_in;
    xlen_t                  sh_s1;
    xlen_t                  sh_s2;
    xlen_t                  sh_s3;
    xlen_t                  sh_res;

    assign is_sub = (prep.op == OP_SUB);
    assign add_b  = is_sub ? ~op2 : op2;
    assign sum    = op1 + add_b + is_sub;  // carry in completes two's complement

    // load/store address, plain sum
    assign addr_res = op1 + op2;

    assign slt  = $signed(op1) < $signed(op2);
    assign sltu = op1 < op2;

    // left shifts reuse the right shifter on reversed bits
    assign is_sll = (prep.op == OP_SLL);
    assign shamt  = op2[`EX_SHAMT_W-1:0];
    assign fill   = (prep.op == OP_SRA) & op1[`EX_XLEN-1];
    assign sh_in  = is_sll ? bit_rev(op1) : op1;

    always_comb begin
        case (shamt[4:3])
            2'd0: sh_s1 = sh_in;
            2'd1: sh_s1 = {{8{fill}}, sh_in[`EX_XLEN-1:8]};
            2'd2: sh_s1 = {{16{fill}}, sh_in[`EX_XLEN-1:16]};
            default: sh_s1 = {{24{fill}}, sh_in[`EX_XLEN-1:24]};
        endcase
        sh_s2 = shamt[2] ? {{4{fill}}, sh_s1[`EX_XLEN-1:4]} : sh_s1;
        case (shamt[1:0])
            2'd0: sh_s3 = sh_s2;
            2'd1: sh_s3 = {fill, sh_s2[`EX_XLEN-1:1]};
            2'd2: sh_s3 = {{2{fill}}, sh_s2[`EX_XLEN-1:2]};
            default: sh_s3 = {{3{fill}}, sh_s2[`EX_XLEN-1:3]};
        endcase
    end

    assign sh_res = is_sll ? bit_rev(sh_s3) : sh_s3;

    always_comb begin
        case (prep.op)
            OP_ADD, OP_SUB:         alu_res = sum;
            OP_SLT:                 alu_res = xlen_t'(slt);
            OP_SLTU:                alu_res = xlen_t'(sltu);
            OP_AND:                 alu_res = op1 & op2;
            OP_OR:                  alu_res = op1 | op2;
            OP_XOR:                 alu_res = op1 ^ op2;
            OP_SLL, OP_SRL, OP_SRA: alu_res = sh_res;
            default:                alu_res = '0;
        endcase
    end

endmodule

// File: source/ex_multiplier.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_multiplier (
    input  ex_pkg::ex_prep_t prep,
    output ex_pkg::xlen_t    mul_res
);

    logic [2*`EX_XLEN-1:0] prod_mag;
    logic [2*`EX_XLEN-1:0] prod;
    logic                  prod_neg;

    // unsigned multiply of magnitudes, 64 bit context
    assign prod_mag = prep.mag_a * prep.mag_b;

    // sign back on when exactly one signed operand was negative
    assign prod_neg = prep.neg_a ^ prep.neg_b;
    assign prod     = prod_neg ? (~prod_mag + 1'b1) : prod_mag;

    assign mul_res = prep.want_high ? prod[2*`EX_XLEN-1:`EX_XLEN]
                                    : prod[`EX_XLEN-1:0];

endmodule

// File: source/ex_divider.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_divider (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                d_hready,
    input  ex_pkg::ex_prep_t    prep,
    output ex_pkg::ex_div_out_t div_out,
    output logic                div_busy
);
    import ex_pkg::*;

    // position of the top set bit counted from the msb, 32 for zero
    function automatic logic [`EX_CNT_W-1:0] lead_one_pos(input xlen_t v);
        logic [`EX_CNT_W-1:0] n;
        n = `EX_CNT_W'(`EX_XLEN);
        for (int i = 0; i < `EX_XLEN; i++) begin
            if (v[i]) begin
                n = `EX_CNT_W'(`EX_XLEN - 1 - i);
            end
        end
        return n;
    endfunction

    logic [`EX_CNT_W-1:0] pos_a;
    logic [`EX_CNT_W-1:0] pos_b;
    logic [`EX_CNT_W-1:0] align_k;
    logic [`EX_CNT_W-1:0] cnt_q;
    logic                 busy_q;
    logic                 valid_q;
    logic                 start;
    logic                 div_zero;
    logic                 fits;
    xlen_t                rem_q;
    xlen_t                quo_q;
    xlen_t                dvs_q;
    xlen_t                rem_diff;

    assign pos_a    = lead_one_pos(prep.mag_a);
    assign pos_b    = lead_one_pos(prep.mag_b);
    assign div_zero = (prep.mag_b == '0);
    assign align_k  = (!div_zero && (pos_b > pos_a)) ? (pos_b - pos_a) : '0;

    assign start = (prep.unit == UNIT_DIV) && d_hready && !busy_q && !valid_q;

    assign fits     = (rem_q >= dvs_q);
    assign rem_diff = rem_q - dvs_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= align_k;  // k+1 steps in total
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q  <= 1'b0;
                valid_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else if (prep.unit != UNIT_DIV) begin
            valid_q <= 1'b0;  // held until the divide leaves the stage
        end
    end

    // restoring shift-subtract, divisor aligned under dividend top bit
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= prep.mag_a;
            dvs_q <= prep.mag_b << align_k;
            quo_q <= div_zero ? '1 : '0;  // zero divisor keeps shifting in ones
        end else if (busy_q) begin
            quo_q <= {quo_q[`EX_XLEN-2:0], fits};
            dvs_q <= dvs_q >> 1;
            if (fits) begin
                rem_q <= rem_diff;
            end
        end
    end

    assign div_out.quo_mag = quo_q;
    assign div_out.rem_mag = rem_q;
    assign div_out.valid   = valid_q;
    assign div_busy        = busy_q;

endmodule

// File: source/ex_result_select.sv
`timescale 1ns/100ps

module ex_result_select (
    input  ex_pkg::ex_prep_t    prep,
    input  ex_pkg::xlen_t       alu_res,
    input  ex_pkg::xlen_t       mul_res,
    input  ex_pkg::ex_div_out_t div_out,
    output ex_pkg::xlen_t       ex_res
);
    import ex_pkg::*;

    logic  neg_quo;
    xlen_t quo;
    xlen_t rem;
    xlen_t div_res;

    // divide by zero keeps the all ones quotient unsigned
    assign neg_quo = (prep.neg_a ^ prep.neg_b) && (prep.mag_b != '0);

    assign quo = neg_quo ? (~div_out.quo_mag + 1'b1) : div_out.quo_mag;
    assign rem = prep.neg_a ? (~div_out.rem_mag + 1'b1) : div_out.rem_mag;  // follows dividend

    assign div_res = prep.want_rem ? rem : quo;

    always_comb begin
        case (prep.unit)
            UNIT_MUL: ex_res = mul_res;
            UNIT_DIV: ex_res = div_out.valid ? div_res : '0;  // zero until done
            default:  ex_res = alu_res;
        endcase
    end

endmodule

// File: source/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           d_hready,
    input  ex_pkg::ex_op_t op,
    input  ex_pkg::xlen_t  op1,
    input  ex_pkg::xlen_t  op2,
    output ex_pkg::xlen_t  ex_res,
    output ex_pkg::xlen_t  addr_res,
    output logic           div_busy
);
    import ex_pkg::*;

    ex_prep_t    prep;
    xlen_t       alu_res;
    xlen_t       mul_res;
    ex_div_out_t div_out;

    ex_operand_prep u_operand_prep (
        .op   (op),
        .op1  (op1),
        .op2  (op2),
        .prep (prep)
    );

    ex_alu u_alu (
        .prep     (prep),
        .op1      (op1),
        .op2      (op2),
        .alu_res  (alu_res),
        .addr_res (addr_res)
    );

    ex_multiplier u_multiplier (
        .prep    (prep),
        .mul_res (mul_res)
    );

    ex_divider u_divider (
        .clk      (clk),
        .rst_n    (rst_n),
        .d_hready (d_hready),
        .prep     (prep),
        .div_out  (div_out),
        .div_busy (div_busy)
    );

    ex_result_select u_result_select (
        .prep    (prep),
        .alu_res (alu_res),
        .mul_res (mul_res),
        .div_out (div_out),
        .ex_res  (ex_res)
    );

endmodule

// File: test/ex_stage_checker.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_checker (
    input logic           clk,
    input logic           rst_n,
    input logic           d_hready,
    input ex_pkg::ex_op_t op,
    input ex_pkg::xlen_t  op1,
    input ex_pkg::xlen_t  op2,
    input ex_pkg::xlen_t  ex_res,
    input ex_pkg::xlen_t  addr_res,
    input logic           div_busy
);
    import ex_pkg::*;

    int unsigned fail_count = 0;
    logic        div_seen;  // busy already seen for the presented divide

    function automatic logic is_div(input ex_op_t f);
        return f inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

    // riscv results of the single cycle forms
    function automatic xlen_t ref_comb(input ex_op_t f, input xlen_t a, input xlen_t b);
        logic [2*`EX_XLEN-1:0]  ea;
        logic [2*`EX_XLEN-1:0]  eb;
        logic [2*`EX_XLEN-1:0]  p;
        logic [`EX_SHAMT_W-1:0] sh;
        sh = b[`EX_SHAMT_W-1:0];
        ea = {{`EX_XLEN{1'b0}}, a};
        eb = {{`EX_XLEN{1'b0}}, b};
        if (f == OP_MULH || f == OP_MULHSU) begin
            ea[2*`EX_XLEN-1:`EX_XLEN] = {`EX_XLEN{a[`EX_XLEN-1]}};
        end
        if (f == OP_MULH) begin
            eb[2*`EX_XLEN-1:`EX_XLEN] = {`EX_XLEN{b[`EX_XLEN-1]}};
        end
        p = ea * eb;  // low 64 bits right for any sign mix
        case (f)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLT:  return xlen_t'($signed(a) < $signed(b));
            OP_SLTU: return xlen_t'(a < b);
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return xlen_t'($signed(a) >>> sh);
            OP_MUL:  return p[`EX_XLEN-1:0];
            default: return p[2*`EX_XLEN-1:`EX_XLEN];
        endcase
    endfunction

    function automatic xlen_t ref_div(input ex_op_t f, input xlen_t a, input xlen_t b);
        logic overflow;
        overflow = (a == {1'b1, {(`EX_XLEN-1){1'b0}}}) && (b == '1);
        if (f == OP_DIVU) begin
            return (b == '0) ? '1 : a / b;
        end else if (f == OP_REMU) begin
            return (b == '0) ? a : a % b;
        end else if (f == OP_DIV) begin
            if (b == '0) begin
                return '1;
            end else if (overflow) begin
                return a;
            end
            return xlen_t'($signed(a) / $signed(b));
        end
        if (b == '0) begin
            return a;
        end else if (overflow) begin
            return '0;
        end
        return xlen_t'($signed(a) % $signed(b));
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_seen <= 1'b0;
        end else if (!is_div(op)) begin
            div_seen <= 1'b0;
        end else if (div_busy) begin
            div_seen <= 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !div_busy)
        else begin
            $error("div_busy was high in the cycle after reset");
            fail_count++;
        end

    a_addr: assert property (@(posedge clk) disable iff (!rst_n) addr_res == op1 + op2)
        else begin
            $error("ERR addr_res %h expected %h", $sampled(addr_res),
                   $sampled(op1) + $sampled(op2));
            fail_count++;
        end

    a_comb: assert property (@(posedge clk) disable iff (!rst_n)
        !is_div(op) |-> ex_res == ref_comb(op, op1, op2))
        else begin
            $error("ERR ex_res %h expected %h (op %0d, op1 %h, op2 %h)", $sampled(ex_res),
                   ref_comb($sampled(op), $sampled(op1), $sampled(op2)),
                   $sampled(op), $sampled(op1), $sampled(op2));
            fail_count++;
        end

    // result checked in the cycle after busy drops
    a_div: assert property (@(posedge clk) disable iff (!rst_n)
        (is_div(op) && $fell(div_busy)) |-> ex_res == ref_div(op, op1, op2))
        else begin
            $error("ERR ex_res %h expected %h (op %0d, op1 %h, op2 %h)", $sampled(ex_res),
                   ref_div($sampled(op), $sampled(op1), $sampled(op2)),
                   $sampled(op), $sampled(op1), $sampled(op2));
            fail_count++;
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (is_div(op) && !d_hready && !div_busy) |=> !div_busy)
        else begin
            $error("divider started while d_hready was low");
            fail_count++;
        end

    a_start: assert property (@(posedge clk) disable iff (!rst_n)
        (is_div(op) && d_hready && !div_busy && !div_seen) |=> div_busy)
        else begin
            $error("divider did not start with d_hready high");
            fail_count++;
        end

endmodule

// File: test/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;
    import ex_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        d_hready;
    ex_op_t      op;
    xlen_t       op1;
    xlen_t       op2;
    xlen_t       ex_res;
    xlen_t       addr_res;
    logic        div_busy;
    int unsigned lcg_state = 73845;

    ex_stage u_ex_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .d_hready (d_hready),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .ex_res   (ex_res),
        .addr_res (addr_res),
        .div_busy (div_busy)
    );

    bind ex_stage ex_stage_checker u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .d_hready (d_hready),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .ex_res   (ex_res),
        .addr_res (addr_res),
        .div_busy (div_busy)
    );

    always #50 clk = ~clk;

    function automatic xlen_t next_rand();
        lcg_state = lcg_state * 1103515245 + 12345;
        return {lcg_state[15:0], lcg_state[31:16]};  // weak low bits moved up
    endfunction

    function automatic xlen_t rand_operand();
        xlen_t r;
        r = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            3'd3: return xlen_t'(r[31:27]);  // small values
            default: return next_rand();
        endcase
    endfunction

    task automatic apply(input ex_op_t f, input xlen_t a, input xlen_t b, input logic ready);
        @(posedge clk);
        #1;
        op       = f;
        op1      = a;
        op2      = b;
        d_hready = ready;
    endtask

    // inputs held until busy has been seen and dropped
    task automatic run_divide(input ex_op_t f, input xlen_t a, input xlen_t b, input int stall);
        int   cycles;
        logic seen_busy;
        apply(OP_ADD, a, b, 1'b1);  // releases the previous result
        apply(f, a, b, stall == 0);
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #1;
        end
        d_hready  = 1'b1;
        cycles    = 0;
        seen_busy = 1'b0;
        while (!(seen_busy && !div_busy)) begin
            @(posedge clk);
            #1;
            if (div_busy) begin
                seen_busy = 1'b1;
            end
            cycles++;
            if (cycles > 40) begin
                $display("divide did not finish within 40 cycles");
                $display("Test failed");
                $fatal(1, "divide timeout");
            end
        end
    endtask

    always @(negedge clk) begin
        if (u_ex_stage.u_checker.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "assertion failed in checker");
        end
    end

    initial begin
        xlen_t  r;
        ex_op_t f;
        rst_n    = 1'b0;
        d_hready = 1'b1;
        op       = OP_ADD;
        op1      = '0;
        op2      = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // alu and multiply forms
        for (int i = 0; i < 14; i++) begin
            for (int n = 0; n < 16; n++) begin
                apply(ex_op_t'(i), rand_operand(), rand_operand(), 1'b1);
            end
        end

        run_divide(OP_DIV, 32'h8000_0000, '1, 0);
        run_divide(OP_REM, 32'h8000_0000, '1, 0);
        run_divide(OP_DIV, 32'h1234_5678, '0, 0);
        run_divide(OP_DIVU, 32'h8765_4321, '0, 1);
        run_divide(OP_REM, 32'hf000_0001, '0, 0);
        run_divide(OP_REMU, 32'h0000_00ff, '0, 2);
        run_divide(OP_DIVU, '1, 32'h1, 3);  // longest run

        for (int n = 0; n < 300; n++) begin
            r = next_rand();
            f = ex_op_t'(r % 18);
            if (f inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
                run_divide(f, rand_operand(), rand_operand(), int'(r[31:30]));
            end else begin
                apply(f, rand_operand(), rand_operand(), r[29]);
            end
        end

        apply(OP_ADD, '0, '0, 1'b1);
        repeat (2) @(posedge clk);
        #1;
        if (u_ex_stage.u_checker.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

// File: ex_stage.f
+incdir+include
source/ex_pkg.sv
source/ex_operand_prep.sv
source/ex_alu.sv
source/ex_multiplier.sv
source/ex_divider.sv
source/ex_result_select.sv
source/ex_stage.sv
test/ex_stage_checker.sv
test/ex_stage_tb.sv
